// ==== verilog/dsp_width_pkg.sv ====
package dsp_width_pkg;

    // operand widths
    localparam int A_W = 32;
    localparam int BC_W = 18;

    // full signed product of a and b
    localparam int PROD_W = A_W + BC_W;

    localparam int ACC_W = 64;   // accumulator and adder
    localparam int Z_W = 50;     // output word

endpackage

// ==== verilog/dsp_mode_pkg.sv ====
package dsp_mode_pkg;

    localparam int SEL_W = 3;

    // second addend of the adder
    localparam logic [SEL_W-1:0] FB_ACC = 3'd0;   // accumulator
    localparam logic [SEL_W-1:0] FB_ZREG = 3'd4;  // registered output word

    // output select where codes 1 to 3 give the rounded word
    localparam logic [SEL_W-1:0] OSEL_PROD = 3'd0;
    localparam logic [SEL_W-1:0] OSEL_ZREG_PROD = 3'd4;  // z_reg takes the product
    localparam int OSEL_ADD_BIT = 1;   // adder sum instead of accumulator

    localparam int RND_W = 3;

    // tie handling of the round step
    localparam logic [RND_W-1:0] RND_NONE = 3'd0;
    localparam logic [RND_W-1:0] RND_HALF_UP = 3'd1;   // asymmetric
    localparam logic [RND_W-1:0] RND_SYM_UP = 3'd2;
    localparam logic [RND_W-1:0] RND_SYM_DOWN = 3'd3;
    localparam logic [RND_W-1:0] RND_EVEN = 3'd4;

    localparam int SHIFT_W = 6;

endpackage

// ==== verilog/dsp_input_stage.sv ====
module dsp_input_stage (
    input  logic                          clock_i,
    input  logic                          s_reset,
    input  logic [dsp_width_pkg::A_W-1:0]  a_i,
    input  logic [dsp_width_pkg::BC_W-1:0] b_i,
    input  logic [dsp_width_pkg::BC_W-1:0] c_i,
    input  logic                          a_reg_i,
    input  logic                          b_reg_i,
    input  logic                          c_reg_i,
    input  logic                          bc_reg_i,
    input  logic                          pre_add_i,
    output logic [dsp_width_pkg::A_W-1:0]  a_op_o,
    output logic [dsp_width_pkg::BC_W-1:0] b_op_o
);

    localparam int BW = dsp_width_pkg::BC_W;

    logic [dsp_width_pkg::A_W-1:0] a_r;
    logic [BW-1:0] b_r;
    logic [BW-1:0] c_r;
    logic [BW-1:0] b_sel;
    logic [BW-1:0] c_sel;
    logic [BW-1:0] sum_raw;
    logic [BW-1:0] sum_sat;
    logic [BW-1:0] sum_r;
    logic [BW-1:0] pre_sum;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            a_r <= '0;
            b_r <= '0;
            c_r <= '0;
        end else begin
            a_r <= a_i;
            b_r <= b_i;
            c_r <= c_i;
        end
    end

    assign a_op_o = a_reg_i ? a_r : a_i;
    assign b_sel = b_reg_i ? b_r : b_i;
    assign c_sel = c_reg_i ? c_r : c_i;

    assign sum_raw = b_sel + c_sel;

    // overflow only when both operands share a sign and the sum flips it
    always_comb begin
        sum_sat = sum_raw;
        if (!b_sel[BW-1] && !c_sel[BW-1] && sum_raw[BW-1]) begin
            sum_sat = {1'b0, {(BW-1){1'b1}}};   // max positive
        end else if (b_sel[BW-1] && c_sel[BW-1] && !sum_raw[BW-1]) begin
            sum_sat = {1'b1, {(BW-1){1'b0}}};   // most negative
        end
    end

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            sum_r <= '0;
        end else begin
            sum_r <= sum_sat;
        end
    end

    assign pre_sum = bc_reg_i ? sum_r : sum_sat;
    assign b_op_o = pre_add_i ? pre_sum : b_sel;

endmodule

// ==== verilog/dsp_mult_acc.sv ====
module dsp_mult_acc (
    input  logic                                clock_i,
    input  logic                                s_reset,
    input  logic [dsp_width_pkg::A_W-1:0]        a_op_i,
    input  logic [dsp_width_pkg::BC_W-1:0]       b_op_i,
    input  logic                                m_reg_i,
    input  logic                                subtract_i,
    input  logic [dsp_mode_pkg::SEL_W-1:0]       feedback_i,
    input  logic [dsp_mode_pkg::SEL_W-1:0]       output_select_i,
    input  logic                                load_acc_i,
    input  logic                                acc_clear_i,
    input  logic [dsp_width_pkg::Z_W-1:0]        z_reg_i,
    output logic [dsp_width_pkg::PROD_W-1:0]     prod_o,
    output logic [dsp_width_pkg::ACC_W-1:0]      acc_sel_o
);

    localparam int AW = dsp_width_pkg::A_W;
    localparam int BW = dsp_width_pkg::BC_W;
    localparam int PW = dsp_width_pkg::PROD_W;
    localparam int CW = dsp_width_pkg::ACC_W;
    localparam int ZW = dsp_width_pkg::Z_W;

    logic sgn_a;
    logic sgn_b;
    logic sgn_p;
    logic [AW-1:0] mag_a;
    logic [BW-1:0] mag_b;
    logic [PW-1:0] mag_p;
    logic [PW-1:0] prod;
    logic [CW-1:0] prod_x;
    logic [CW-1:0] prod_r;
    logic [CW-1:0] prod_sel;
    logic [CW-1:0] add_a;
    logic [CW-1:0] add_b;
    logic [CW-1:0] add_o;
    logic [CW-1:0] acc;

    // sign-magnitude multiply
    assign sgn_a = a_op_i[AW-1];
    assign sgn_b = b_op_i[BW-1];
    assign mag_a = sgn_a ? (~a_op_i + 1'b1) : a_op_i;
    assign mag_b = sgn_b ? (~b_op_i + 1'b1) : b_op_i;
    assign mag_p = mag_a * mag_b;
    assign sgn_p = sgn_a ^ sgn_b;
    assign prod = sgn_p ? (~mag_p + 1'b1) : mag_p;

    assign prod_x = {{(CW-PW){prod[PW-1]}}, prod};

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            prod_r <= '0;
        end else begin
            prod_r <= prod_x;
        end
    end

    assign prod_sel = m_reg_i ? prod_r : prod_x;
    assign prod_o = prod_sel[PW-1:0];

    assign add_a = subtract_i ? (~prod_sel + 1'b1) : prod_sel;

    // any code other than these two adds nothing
    always_comb begin
        case (feedback_i)
            dsp_mode_pkg::FB_ACC:  add_b = acc;
            dsp_mode_pkg::FB_ZREG: add_b = {{(CW-ZW){z_reg_i[ZW-1]}}, z_reg_i};
            default:               add_b = '0;
        endcase
    end

    assign add_o = add_a + add_b;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            acc <= '0;
        end else if (acc_clear_i) begin   // clear wins over load
            acc <= '0;
        end else if (load_acc_i) begin
            acc <= add_o;
        end
    end

    assign acc_sel_o = output_select_i[dsp_mode_pkg::OSEL_ADD_BIT] ? add_o : acc;

endmodule

// ==== verilog/dsp_output_stage.sv ====
module dsp_output_stage (
    input  logic                               clock_i,
    input  logic                               s_reset,
    input  logic [dsp_width_pkg::ACC_W-1:0]     acc_sel_i,
    input  logic [dsp_width_pkg::PROD_W-1:0]    prod_i,
    input  logic [dsp_mode_pkg::RND_W-1:0]      round_i,
    input  logic [dsp_mode_pkg::SHIFT_W-1:0]    shift_right_i,
    input  logic                               saturate_i,
    input  logic [dsp_mode_pkg::SEL_W-1:0]      output_select_i,
    output logic [dsp_width_pkg::Z_W-1:0]       z_o,
    output logic [dsp_width_pkg::Z_W-1:0]       z_reg_o
);

    localparam int CW = dsp_width_pkg::ACC_W;
    localparam int ZW = dsp_width_pkg::Z_W;

    logic          val_sign;
    logic [CW-1:0] one_half;
    logic [CW-1:0] frac_mask;
    logic [CW-1:0] val_frac;
    logic [CW-1:0] val_int;
    logic          tie;
    logic          skip_add;
    logic [CW-1:0] acc_rnd;
    logic [CW-1:0] acc_shr;
    logic          in_range;
    logic [ZW-1:0] z_sat;
    logic [ZW-1:0] z_rnd;
    logic [ZW-1:0] z_reg;

    assign val_sign = acc_sel_i[CW-1];

    // half of one output step or zero without a shift
    assign one_half = (shift_right_i == '0) ? '0 :
                      ({{(CW-1){1'b0}}, 1'b1} << (shift_right_i - 1'b1));
    assign frac_mask = ~({CW{1'b1}} << shift_right_i);
    assign val_frac = acc_sel_i & frac_mask;
    assign val_int = $signed(acc_sel_i) >>> shift_right_i;
    assign tie = (val_frac == one_half);

    always_comb begin
        skip_add = 1'b0;
        case (round_i)
            dsp_mode_pkg::RND_NONE:     skip_add = 1'b1;
            dsp_mode_pkg::RND_HALF_UP:  skip_add = 1'b0;
            dsp_mode_pkg::RND_SYM_UP:   skip_add = tie && val_sign;
            dsp_mode_pkg::RND_SYM_DOWN: skip_add = tie && !val_sign;
            dsp_mode_pkg::RND_EVEN:     skip_add = tie && !val_int[0];
            default:                    skip_add = 1'b1;   // unused codes pass through
        endcase
    end

    assign acc_rnd = skip_add ? acc_sel_i : (acc_sel_i + one_half);
    assign acc_shr = $signed(acc_rnd) >>> shift_right_i;

    // upper bits all equal to the z sign bit means it fits
    assign in_range = (acc_shr[CW-1:ZW-1] == '0) || (acc_shr[CW-1:ZW-1] == '1);
    assign z_sat = in_range ? acc_shr[ZW-1:0] : {acc_shr[CW-1], {(ZW-1){~acc_shr[CW-1]}}};

    assign z_rnd = saturate_i ? z_sat : acc_shr[ZW-1:0];

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            z_reg <= '0;
        end else if (output_select_i == dsp_mode_pkg::OSEL_ZREG_PROD) begin
            z_reg <= prod_i;
        end else begin
            z_reg <= z_rnd;
        end
    end

    assign z_reg_o = z_reg;

    // codes 4 to 7 all show the register
    always_comb begin
        if (output_select_i == dsp_mode_pkg::OSEL_PROD) begin
            z_o = prod_i;
        end else if (output_select_i[2]) begin
            z_o = z_reg;
        end else begin
            z_o = z_rnd;
        end
    end

endmodule

// ==== verilog/dsp_mac_top.sv ====
module dsp_mac_top (
    input  logic                            clock_i,
    input  logic                            s_reset,
    input  logic [dsp_width_pkg::A_W-1:0]    a_i,
    input  logic [dsp_width_pkg::BC_W-1:0]   b_i,
    input  logic [dsp_width_pkg::BC_W-1:0]   c_i,
    input  logic                            load_acc_i,
    input  logic                            acc_clear_i,
    input  logic [dsp_mode_pkg::SEL_W-1:0]   feedback_i,
    input  logic [dsp_mode_pkg::SEL_W-1:0]   output_select_i,
    input  logic [dsp_mode_pkg::RND_W-1:0]   round_i,
    input  logic [dsp_mode_pkg::SHIFT_W-1:0] shift_right_i,
    input  logic                            saturate_i,
    input  logic                            subtract_i,
    input  logic                            pre_add_i,
    input  logic                            a_reg_i,
    input  logic                            b_reg_i,
    input  logic                            c_reg_i,
    input  logic                            bc_reg_i,
    input  logic                            m_reg_i,
    output logic [dsp_width_pkg::Z_W-1:0]    z_o
);

    logic [dsp_width_pkg::A_W-1:0]    a_op;
    logic [dsp_width_pkg::BC_W-1:0]   b_op;   // b or the pre-adder sum
    logic [dsp_width_pkg::PROD_W-1:0] prod;
    logic [dsp_width_pkg::ACC_W-1:0]  acc_sel;
    logic [dsp_width_pkg::Z_W-1:0]    z_reg;  // feedback for FB_ZREG

    dsp_input_stage input_stage_i (
        .clock_i   (clock_i),
        .s_reset   (s_reset),
        .a_i       (a_i),
        .b_i       (b_i),
        .c_i       (c_i),
        .a_reg_i   (a_reg_i),
        .b_reg_i   (b_reg_i),
        .c_reg_i   (c_reg_i),
        .bc_reg_i  (bc_reg_i),
        .pre_add_i (pre_add_i),
        .a_op_o    (a_op),
        .b_op_o    (b_op)
    );

    dsp_mult_acc mult_acc_i (
        .clock_i         (clock_i),
        .s_reset         (s_reset),
        .a_op_i          (a_op),
        .b_op_i          (b_op),
        .m_reg_i         (m_reg_i),
        .subtract_i      (subtract_i),
        .feedback_i      (feedback_i),
        .output_select_i (output_select_i),
        .load_acc_i      (load_acc_i),
        .acc_clear_i     (acc_clear_i),
        .z_reg_i         (z_reg),
        .prod_o          (prod),
        .acc_sel_o       (acc_sel)
    );

    dsp_output_stage output_stage_i (
        .clock_i         (clock_i),
        .s_reset         (s_reset),
        .acc_sel_i       (acc_sel),
        .prod_i          (prod),
        .round_i         (round_i),
        .shift_right_i   (shift_right_i),
        .saturate_i      (saturate_i),
        .output_select_i (output_select_i),
        .z_o             (z_o),
        .z_reg_o         (z_reg)
    );

endmodule

// ==== sim/dsp_mac_sva.sv ====
module dsp_mac_sva (
    input  logic                               clock_i,
    input  logic                               s_reset,
    input  logic                               saturate_i,
    input  logic [dsp_mode_pkg::SEL_W-1:0]      output_select_i,
    input  logic [dsp_width_pkg::PROD_W-1:0]    prod_i,
    input  logic [dsp_width_pkg::ACC_W-1:0]     acc_shr_i,
    input  logic [dsp_width_pkg::Z_W-1:0]       z_rnd_i,
    input  logic [dsp_width_pkg::Z_W-1:0]       z_reg_i
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CW = dsp_width_pkg::ACC_W;
    localparam int ZW = dsp_width_pkg::Z_W;

    // signed Z_W limits widened to the accumulator
    localparam logic signed [CW-1:0] Z_MAX = {{(CW-ZW+1){1'b0}}, {(ZW-1){1'b1}}};
    localparam logic signed [CW-1:0] Z_MIN = {{(CW-ZW+1){1'b1}}, {(ZW-1){1'b0}}};

    zreg_reset: assert property (@(posedge clock_i) s_reset |-> z_reg_i == '0)
        else $error("z_reg_o not zero while reset is high");

    sat_clamp: assert property (@(posedge clock_i) disable iff (s_reset)
        saturate_i |-> (($signed(acc_shr_i) > Z_MAX) ? (z_rnd_i == Z_MAX[ZW-1:0]) :
                        ($signed(acc_shr_i) < Z_MIN) ? (z_rnd_i == Z_MIN[ZW-1:0]) :
                        (z_rnd_i == acc_shr_i[ZW-1:0])))
        else $error("saturated word outside the signed output range");

    // z_reg still holds its reset value on the first edge after reset
    zreg_capture: assert property (@(posedge clock_i) disable iff (s_reset)
        !$past(s_reset) |-> z_reg_i == $past((output_select_i ==
            dsp_mode_pkg::OSEL_ZREG_PROD) ? prod_i : z_rnd_i))
        else $error("z_reg_o does not hold the value selected on the previous edge");

endmodule

bind dsp_output_stage dsp_mac_sva sva_i (
    .clock_i         (clock_i),
    .s_reset         (s_reset),
    .saturate_i      (saturate_i),
    .output_select_i (output_select_i),
    .prod_i          (prod_i),
    .acc_shr_i       (acc_shr),
    .z_rnd_i         (z_rnd),
    .z_reg_i         (z_reg_o)
);

// ==== sim/tb_dsp_mac.sv ====
module tb_dsp_mac;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int A_W = dsp_width_pkg::A_W;
    localparam int BC_W = dsp_width_pkg::BC_W;
    localparam int Z_W = dsp_width_pkg::Z_W;
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_TESTS = 32;
    localparam int RAND_TESTS = 24;
    localparam int NAME_W = 8 * 24;

    logic clock_i;
    logic s_reset;
    logic [A_W-1:0] a;
    logic [BC_W-1:0] b;
    logic [BC_W-1:0] c;
    logic load_acc;
    logic acc_clear;
    logic [dsp_mode_pkg::SEL_W-1:0] feedback;
    logic [dsp_mode_pkg::SEL_W-1:0] output_select;
    logic [dsp_mode_pkg::RND_W-1:0] round_mode;
    logic [dsp_mode_pkg::SHIFT_W-1:0] shift_right;
    logic saturate, subtract, pre_add;
    logic a_reg, b_reg, c_reg, bc_reg, m_reg;
    logic [Z_W-1:0] z;

    // golden tests with cfg columns in file order fb .. m_reg
    logic [NAME_W-1:0] g_name [MAX_TESTS];
    int g_cfg [MAX_TESTS][12];
    logic [A_W-1:0] g_a [MAX_TESTS];
    logic [BC_W-1:0] g_b [MAX_TESTS];
    logic [BC_W-1:0] g_c [MAX_TESTS];
    int g_loads [MAX_TESTS];
    int g_clr [MAX_TESTS];
    int g_chk [MAX_TESTS];
    logic [Z_W-1:0] g_z [MAX_TESTS];

    int num_golden = 0;
    int pass_count = 0;
    int fail_count = 0;
    bit file_error = 0;
    int cycle_count = 0;
    int cycle_limit = 0;   // 0 until the golden file is read
    integer seed;

    dsp_mac_top dut_i (
        .clock_i         (clock_i),
        .s_reset         (s_reset),
        .a_i             (a),
        .b_i             (b),
        .c_i             (c),
        .load_acc_i      (load_acc),
        .acc_clear_i     (acc_clear),
        .feedback_i      (feedback),
        .output_select_i (output_select),
        .round_i         (round_mode),
        .shift_right_i   (shift_right),
        .saturate_i      (saturate),
        .subtract_i      (subtract),
        .pre_add_i       (pre_add),
        .a_reg_i         (a_reg),
        .b_reg_i         (b_reg),
        .c_reg_i         (c_reg),
        .bc_reg_i        (bc_reg),
        .m_reg_i         (m_reg),
        .z_o             (z)
    );

    initial begin
        clock_i = 1'b0;
        forever #(CLK_PERIOD / 2) clock_i = ~clock_i;
    end

    always @(posedge clock_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_z(input logic [NAME_W-1:0] name, input logic [Z_W-1:0] expected,
                           input logic [Z_W-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %0s expected %h actual %h", name, expected, actual);
            fail_count++;
            $display("test %0s failed", name);
        end else begin
            pass_count++;
            $display("test %0s passed", name);
        end
    endtask

    task automatic set_defaults;
        feedback = dsp_mode_pkg::FB_ACC;
        output_select = dsp_mode_pkg::OSEL_PROD;
        round_mode = dsp_mode_pkg::RND_NONE;
        shift_right = '0;
        saturate = 1'b0;
        subtract = 1'b0;
        pre_add = 1'b0;
        a_reg = 1'b0;
        b_reg = 1'b0;
        c_reg = 1'b0;
        bc_reg = 1'b0;
        m_reg = 1'b0;
    endtask

    task automatic load_golden;
        int fd;
        int cnt;
        int fld [12];
        int ld, clr, chk;
        bit done;
        logic [8*256-1:0] line;
        logic [NAME_W-1:0] name_v;
        logic [A_W-1:0] a_v;
        logic [BC_W-1:0] b_v, c_v;
        logic [Z_W-1:0] z_v;
        done = 1'b0;
        fd = $fopen("sim/dsp_mac_golden.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open sim/dsp_mac_golden.txt");
            file_error = 1'b1;
            done = 1'b1;
        end
        while (!done) begin
            line = '0;
            name_v = '0;
            if ($fgets(line, fd) == 0) begin
                done = 1'b1;
            end else begin
                cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %h %h %h %d %d %d %h",
                              name_v, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                              fld[7], fld[8], fld[9], fld[10], fld[11], a_v, b_v, c_v,
                              ld, clr, chk, z_v);
                if (cnt <= 0 || name_v == "#") begin
                    cnt = 0;   // blank or comment
                end else if (cnt != 20 || chk < 1 || num_golden >= MAX_TESTS) begin
                    $display("error: golden line for %0s is malformed or one too many", name_v);
                    file_error = 1'b1;
                end else begin
                    g_name[num_golden] = name_v;
                    foreach (fld[k]) g_cfg[num_golden][k] = fld[k];
                    g_a[num_golden] = a_v;
                    g_b[num_golden] = b_v;
                    g_c[num_golden] = c_v;
                    g_loads[num_golden] = ld;
                    g_clr[num_golden] = clr;
                    g_chk[num_golden] = chk;
                    g_z[num_golden] = z_v;
                    num_golden++;
                end
            end
        end
        if (fd != 0) $fclose(fd);
        if (num_golden == 0) begin
            $display("error: golden file holds no tests");
            file_error = 1'b1;
        end
    endtask

    task automatic run_golden(input int idx);
        // clear the accumulator and let z_reg take the zero
        @(negedge clock_i);
        set_defaults();
        output_select = 3'd1;
        feedback = 3'd7;   // adds zero
        a = '0;
        b = '0;
        c = '0;
        acc_clear = 1'b1;
        @(negedge clock_i);
        acc_clear = 1'b0;
        @(negedge clock_i);
        feedback = g_cfg[idx][0][dsp_mode_pkg::SEL_W-1:0];
        output_select = g_cfg[idx][1][dsp_mode_pkg::SEL_W-1:0];
        round_mode = g_cfg[idx][2][dsp_mode_pkg::RND_W-1:0];
        shift_right = g_cfg[idx][3][dsp_mode_pkg::SHIFT_W-1:0];
        saturate = (g_cfg[idx][4] != 0);
        subtract = (g_cfg[idx][5] != 0);
        pre_add = (g_cfg[idx][6] != 0);
        a_reg = (g_cfg[idx][7] != 0);
        b_reg = (g_cfg[idx][8] != 0);
        c_reg = (g_cfg[idx][9] != 0);
        bc_reg = (g_cfg[idx][10] != 0);
        m_reg = (g_cfg[idx][11] != 0);
        @(negedge clock_i);   // second settle cycle
        @(negedge clock_i);
        a = g_a[idx];
        b = g_b[idx];
        c = g_c[idx];
        for (int t = 0; t < g_chk[idx]; t++) begin
            if (t > 0) @(negedge clock_i);
            load_acc = (t < g_loads[idx]);
            acc_clear = (t == g_clr[idx]);
        end
        @(negedge clock_i);
        check_z(g_name[idx], g_z[idx], z);
        load_acc = 1'b0;
        acc_clear = 1'b0;
    endtask

    task automatic run_random;
        int rnd_word;
        logic [A_W-1:0] a_v;
        logic [BC_W-1:0] b_v;
        logic signed [Z_W-1:0] expected;
        logic [NAME_W-1:0] name_v;
        @(negedge clock_i);
        set_defaults();   // all registers off so z is the product
        a = '0;
        b = '0;
        c = '0;
        repeat (2) @(negedge clock_i);
        for (int i = 0; i < RAND_TESTS; i++) begin
            a_v = $random(seed);
            rnd_word = $random(seed);
            b_v = rnd_word[BC_W-1:0];
            a = a_v;
            b = b_v;
            expected = $signed(a_v) * $signed(b_v);
            #(CLK_PERIOD / 4);   // product is there before the next rising edge
            $sformat(name_v, "rand_mul_%0d", i);
            check_z(name_v, expected, z);
            @(negedge clock_i);
        end
    endtask

    initial begin
        seed = 32'h5a47_b4ad;
        s_reset = 1'b1;
        set_defaults();
        a = '0;
        b = '0;
        c = '0;
        load_acc = 1'b0;
        acc_clear = 1'b0;
        load_golden();
        cycle_limit = num_golden * 12 + RAND_TESTS * 4 + 40;
        repeat (RESET_CYCLES) @(posedge clock_i);
        @(negedge clock_i);
        s_reset = 1'b0;
        for (int i = 0; i < num_golden; i++) begin
            run_golden(i);
        end
        run_random();
        if (file_error) fail_count++;
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/dsp_width_pkg.sv
verilog/dsp_mode_pkg.sv
verilog/dsp_input_stage.sv
verilog/dsp_mult_acc.sv
verilog/dsp_output_stage.sv
verilog/dsp_mac_top.sv
sim/dsp_mac_sva.sv
sim/tb_dsp_mac.sv

// ==== sim/dsp_mac_golden.txt ====
# name fb osel rnd shift sat sub pre a_reg b_reg c_reg bc_reg m_reg a b c loads clr chk z
# a b c z in hex, clr is the cycle of the clear pulse (15 for none), chk is the sample cycle
reg_lat_1        0 0 0 0 0 0 0 1 1 0 0 1 00000007 00003 00000 0 15 1 0000000000000
reg_lat_2        0 0 0 0 0 0 0 1 1 0 0 1 00000007 00003 00000 0 15 2 0000000000015
reg_neg          0 0 0 0 0 0 0 1 1 0 0 1 FFFFFFFB 00003 00000 0 15 2 3FFFFFFFFFFF1
preadd_pos       0 0 0 0 0 0 1 0 0 0 0 0 00000001 1FFF0 00100 0 15 1 000000001FFFF
preadd_neg       0 0 0 0 0 0 1 0 0 0 0 0 00000001 20010 3FF00 0 15 1 3FFFFFFFE0000
preadd_reg       0 0 0 0 0 0 1 0 0 0 1 0 00000002 00010 00020 0 15 1 0000000000060
acc_sum          0 1 0 0 0 0 0 0 0 0 0 0 00000064 00007 00000 3 15 3 0000000000834
acc_sub          0 1 0 0 0 1 0 0 0 0 0 0 00000064 00007 00000 3 15 3 3FFFFFFFFF7CC
acc_clear        0 1 0 0 0 0 0 0 0 0 0 0 00000064 00007 00000 3 3 4 0000000000000
rnd_none         0 3 0 4 0 0 0 0 0 0 0 0 00000028 00001 00000 0 15 1 0000000000002
rnd_half_up      0 3 1 4 0 0 0 0 0 0 0 0 00000028 00001 00000 0 15 1 0000000000003
rnd_half_up_neg  0 3 1 4 0 0 0 0 0 0 0 0 FFFFFFD8 00001 00000 0 15 1 3FFFFFFFFFFFE
rnd_sym_up_neg   0 3 2 4 0 0 0 0 0 0 0 0 FFFFFFD8 00001 00000 0 15 1 3FFFFFFFFFFFD
rnd_sym_down_pos 0 3 3 4 0 0 0 0 0 0 0 0 00000028 00001 00000 0 15 1 0000000000002
rnd_sym_down_neg 0 3 3 4 0 0 0 0 0 0 0 0 FFFFFFD8 00001 00000 0 15 1 3FFFFFFFFFFFE
rnd_even_pos     0 3 4 4 0 0 0 0 0 0 0 0 00000028 00001 00000 0 15 1 0000000000002
rnd_even_odd     0 3 4 4 0 0 0 0 0 0 0 0 00000038 00001 00000 0 15 1 0000000000004
sat_pos          0 1 0 0 1 0 0 0 0 0 0 0 7FFFFFFF 1FFFF 00000 3 15 3 1FFFFFFFFFFFF
sat_neg          0 1 0 0 1 1 0 0 0 0 0 0 7FFFFFFF 1FFFF 00000 3 15 3 2000000000000
zreg_lat         0 4 0 0 0 0 0 0 0 0 0 0 00000009 00005 00000 0 15 1 000000000002D
zreg_fb          4 6 0 0 0 0 0 0 0 0 0 0 00000009 00005 00000 3 15 3 0000000000087
